/* design/corr_config_pkg.sv */
// correlator configuration package: parameter defaults and the sample counter type.
`default_nettype none

package corr_config_pkg;

	// ******************************
	// default core dimensions
	// ******************************

	// number of detector lines sampled in parallel.
	parameter int NUM_INPUTS_DEF = 4;

	// auto-correlation lags per line, lag 1 up to this value.
	parameter int LAG_AUTO_DEF = 2;

	// width of every saturating accumulator.
	parameter int RESOLUTION_DEF = 16;

	// ******************************
	// shared vector types
	// ******************************

	// samples seen inside one integration window, saturating.
	typedef logic [31:0] sample_count_t;

endpackage

`default_nettype wire

/* design/corr_frame_pkg.sv */
// frame package: field widths, header and nibble types, header builder, serializer states.
`default_nettype none

package corr_frame_pkg;

	// ******************************
	// frame layout
	// ******************************

	parameter int HEADER_BITS = 16; // configuration word at the head of each frame.
	parameter int COUNT_BITS = 32; // window sample count that follows the header.

	typedef logic [HEADER_BITS-1:0] header_t;
	typedef logic [3:0] nibble_t; // one hex digit on the output.

	// serializer FSM.
	typedef enum logic {
		ser_idle,
		ser_send
	} ser_state_t;

	// packs the core dimensions into the header word.
	function automatic header_t make_header(int num_inputs, int lag_auto, int resolution);
		header_t h;
		h[15:12] = 4'(num_inputs - 1); // line count minus one.
		h[11:8] = 4'(lag_auto);
		h[7:0] = 8'(resolution);
		return h;
	endfunction

endpackage

`default_nettype wire

/* design/pulse_if.sv */
// pulse_if and result_if interfaces between the sampler, correlator and serializer stages.
`default_nettype none

interface pulse_if #(
	parameter int NUM_INPUTS = corr_config_pkg::NUM_INPUTS_DEF
);
	logic [NUM_INPUTS-1:0] pulses; // one-cycle edge strobes, one per line.
	logic active; // sample was taken with integrate high.
	logic window_start;
	logic window_end;

	modport source (output pulses, active, window_start, window_end);
	modport sink (input pulses, active, window_start, window_end);
endinterface

interface result_if #(
	parameter int NUM_INPUTS = corr_config_pkg::NUM_INPUTS_DEF,
	parameter int LAG_AUTO = corr_config_pkg::LAG_AUTO_DEF,
	parameter int RESOLUTION = corr_config_pkg::RESOLUTION_DEF
);
	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2;

	logic [NUM_INPUTS*RESOLUTION-1:0] counts;
	logic [NUM_INPUTS*LAG_AUTO*RESOLUTION-1:0] autos; // line-major, lag 1 first.
	logic [NUM_PAIRS*RESOLUTION-1:0] crosses; // pair order (0,1), (0,2) and on.
	corr_config_pkg::sample_count_t sample_count;
	logic results_valid;

	modport source (output counts, autos, crosses, sample_count, results_valid);
	modport sink (input counts, autos, crosses, sample_count, results_valid);
endinterface

`default_nettype wire

/* design/line_sampler.sv */
// line_sampler: input registers, invert mask, rising-edge detection and window strobes.
`default_nettype none

module line_sampler #(
	parameter int NUM_INPUTS = corr_config_pkg::NUM_INPUTS_DEF
) (
	input wire pllclk,
	input wire reset,
	input wire [NUM_INPUTS-1:0] line_in,
	input wire [NUM_INPUTS-1:0] invert,
	input wire integrate,
	pulse_if.source pulse_out
);

	typedef logic [NUM_INPUTS-1:0] line_t;

	line_t line_q; // first stage, already inverted where asked.
	line_t line_prev; // sample before line_q, for edge detection.
	logic integ_q;

	// ******************************
	// stage one: input registers
	// ******************************

	always_ff @(posedge pllclk) begin
		line_q <= line_in ^ invert;
		if (reset) begin
			integ_q <= 1'b0;
		end else begin
			integ_q <= integrate;
		end
	end

	// ******************************
	// stage two: edges and window
	// ******************************

	// line_prev keeps tracking during reset so that a line already high is no edge.
	always_ff @(posedge pllclk) begin
		line_prev <= line_q;
		if (reset) begin
			pulse_out.pulses <= '0;
			pulse_out.active <= 1'b0;
			pulse_out.window_start <= 1'b0;
			pulse_out.window_end <= 1'b0;
		end else begin
			pulse_out.pulses <= line_q & ~line_prev;
			pulse_out.active <= integ_q;
			pulse_out.window_start <= integ_q & ~pulse_out.active; // first active sample.
			pulse_out.window_end <= ~integ_q & pulse_out.active; // first sample after the run.
		end
	end

endmodule

`default_nettype wire

/* design/lag_correlator.sv */
// lag_correlator: pulse history plus saturating count, auto-lag, baseline and sample accumulators.
`default_nettype none

module lag_correlator #(
	parameter int NUM_INPUTS = corr_config_pkg::NUM_INPUTS_DEF,
	parameter int LAG_AUTO = corr_config_pkg::LAG_AUTO_DEF,
	parameter int RESOLUTION = corr_config_pkg::RESOLUTION_DEF
) (
	input wire pllclk,
	input wire reset,
	pulse_if.sink pulse_in,
	result_if.source result_out
);

	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_FIELDS = NUM_INPUTS + NUM_INPUTS * LAG_AUTO + NUM_PAIRS;

	typedef logic [NUM_INPUTS-1:0] line_t;
	typedef logic [RESOLUTION-1:0] acc_t;

	line_t hist [LAG_AUTO]; // hist[d] holds the pulses of d+1 samples ago.
	acc_t counts_q [NUM_INPUTS];
	acc_t autos_q [NUM_INPUTS][LAG_AUTO];
	acc_t crosses_q [NUM_PAIRS];
	corr_config_pkg::sample_count_t sample_q;
	logic [NUM_FIELDS*RESOLUTION-1:0] all_acc;

	// loads the increment at window start, otherwise adds it and holds at full scale.
	function automatic acc_t acc_next(acc_t cur, logic inc, logic load);
		return load ? acc_t'(inc) : cur + acc_t'(inc && (cur != '1));
	endfunction

	// ******************************
	// history and result strobe
	// ******************************

	always_ff @(posedge pllclk) begin
		if (reset) begin
			for (int d = 0; d < LAG_AUTO; d++) begin
				hist[d] <= '0;
			end
			result_out.results_valid <= 1'b0;
		end else begin
			hist[0] <= pulse_in.pulses; // edges before the window still pair up.
			for (int d = 1; d < LAG_AUTO; d++) begin
				hist[d] <= hist[d-1];
			end
			result_out.results_valid <= pulse_in.window_end;
		end
	end

	// ******************************
	// accumulators
	// ******************************

	always_ff @(posedge pllclk) begin
		if (pulse_in.active) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				counts_q[i] <= acc_next(counts_q[i], pulse_in.pulses[i], pulse_in.window_start);
				for (int d = 0; d < LAG_AUTO; d++) begin
					autos_q[i][d] <= acc_next(autos_q[i][d], pulse_in.pulses[i] & hist[d][i],
						pulse_in.window_start);
				end
			end
			if (pulse_in.window_start) begin
				sample_q <= 32'd1;
			end else begin
				sample_q <= sample_q + 32'(sample_q != '1);
			end
		end
	end

	genvar gi, gj, gd;
	generate
		for (gi = 0; gi < NUM_INPUTS; gi++) begin : g_line
			assign result_out.counts[gi*RESOLUTION +: RESOLUTION] = counts_q[gi];
			for (gd = 0; gd < LAG_AUTO; gd++) begin : g_lag
				assign result_out.autos[(gi*LAG_AUTO+gd)*RESOLUTION +: RESOLUTION] =
					autos_q[gi][gd];
			end
			for (gj = gi + 1; gj < NUM_INPUTS; gj++) begin : g_pair
				localparam int P = gi * (2 * NUM_INPUTS - gi - 1) / 2 + gj - gi - 1;
				always_ff @(posedge pllclk) begin
					if (pulse_in.active) begin
						crosses_q[P] <= acc_next(crosses_q[P],
							pulse_in.pulses[gi] & pulse_in.pulses[gj], pulse_in.window_start);
					end
				end
				assign result_out.crosses[P*RESOLUTION +: RESOLUTION] = crosses_q[P];
			end
		end
	endgenerate

	assign result_out.sample_count = sample_q;
	assign all_acc = {result_out.crosses, result_out.autos, result_out.counts};

	// ******************************
	// checks
	// ******************************

	valid_one_cycle: assert property (
		@(posedge pllclk) disable iff (reset)
		result_out.results_valid |=> !result_out.results_valid
	) else $error("results_valid held for two cycles");

	generate
		for (gi = 0; gi < NUM_FIELDS; gi++) begin : g_mono
			acc_monotonic: assert property (
				@(posedge pllclk) disable iff (reset)
				(pulse_in.active && !pulse_in.window_start) |=>
					all_acc[gi*RESOLUTION +: RESOLUTION] >=
					$past(all_acc[gi*RESOLUTION +: RESOLUTION])
			) else $error("accumulator %0d decreased inside a window", gi);
		end
	endgenerate

	samples_monotonic: assert property (
		@(posedge pllclk) disable iff (reset)
		(pulse_in.active && !pulse_in.window_start) |=> sample_q >= $past(sample_q)
	) else $error("sample count decreased inside a window");

endmodule

`default_nettype wire

/* design/frame_serializer.sv */
// frame_serializer: builds the result frame and shifts it out one nibble per clock.
`default_nettype none

module frame_serializer #(
	parameter int NUM_INPUTS = corr_config_pkg::NUM_INPUTS_DEF,
	parameter int LAG_AUTO = corr_config_pkg::LAG_AUTO_DEF,
	parameter int RESOLUTION = corr_config_pkg::RESOLUTION_DEF
) (
	input wire pllclk,
	input wire reset,
	result_if.sink result_in,
	output corr_frame_pkg::nibble_t nibble,
	output logic nibble_valid,
	output logic frame_busy,
	output logic overrun
);

	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_FIELDS = NUM_INPUTS + NUM_INPUTS * LAG_AUTO + NUM_PAIRS;
	localparam int FRAME_BITS = corr_frame_pkg::HEADER_BITS + corr_frame_pkg::COUNT_BITS
		+ NUM_FIELDS * RESOLUTION;
	localparam int FRAME_NIBBLES = (FRAME_BITS + 3) / 4; // the tail is zero padded.
	localparam int FRAME_W = FRAME_NIBBLES * 4;
	localparam int CNT_W = $clog2(FRAME_NIBBLES);
	localparam int COUNTS_TOP = FRAME_W - corr_frame_pkg::HEADER_BITS
		- corr_frame_pkg::COUNT_BITS - 1;
	localparam int AUTOS_TOP = COUNTS_TOP - NUM_INPUTS * RESOLUTION;
	localparam int CROSSES_TOP = AUTOS_TOP - NUM_INPUTS * LAG_AUTO * RESOLUTION;
	localparam corr_frame_pkg::header_t HEADER =
		corr_frame_pkg::make_header(NUM_INPUTS, LAG_AUTO, RESOLUTION);

	typedef logic [FRAME_W-1:0] frame_t;
	typedef logic [CNT_W-1:0] nib_count_t;

	corr_frame_pkg::ser_state_t state;
	frame_t frame_word;
	frame_t shreg; // current nibble sits at the top.
	nib_count_t remaining; // nibbles left after the one on the output.

	// ******************************
	// frame assembly
	// ******************************

	// lowest index first within each field group.
	always_comb begin
		frame_word = '0;
		frame_word[FRAME_W-1 -: corr_frame_pkg::HEADER_BITS] = HEADER;
		frame_word[FRAME_W-corr_frame_pkg::HEADER_BITS-1 -: corr_frame_pkg::COUNT_BITS] =
			result_in.sample_count;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			frame_word[COUNTS_TOP - i*RESOLUTION -: RESOLUTION] =
				result_in.counts[i*RESOLUTION +: RESOLUTION];
		end
		for (int f = 0; f < NUM_INPUTS * LAG_AUTO; f++) begin
			frame_word[AUTOS_TOP - f*RESOLUTION -: RESOLUTION] =
				result_in.autos[f*RESOLUTION +: RESOLUTION];
		end
		for (int p = 0; p < NUM_PAIRS; p++) begin
			frame_word[CROSSES_TOP - p*RESOLUTION -: RESOLUTION] =
				result_in.crosses[p*RESOLUTION +: RESOLUTION];
		end
	end

	// ******************************
	// output FSM
	// ******************************

	always_ff @(posedge pllclk) begin
		if (reset) begin
			state <= corr_frame_pkg::ser_idle;
			remaining <= '0;
			overrun <= 1'b0;
		end else begin
			case (state)
				corr_frame_pkg::ser_idle: begin
					if (result_in.results_valid) begin
						state <= corr_frame_pkg::ser_send;
						remaining <= nib_count_t'(FRAME_NIBBLES - 1);
					end
				end
				default: begin
					if (remaining == '0) begin
						state <= corr_frame_pkg::ser_idle;
					end
					remaining <= remaining - 1'b1;
				end
			endcase
			if (result_in.results_valid && state == corr_frame_pkg::ser_send) begin
				overrun <= 1'b1; // frame dropped, sticky until reset.
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (state == corr_frame_pkg::ser_idle) begin
			shreg <= frame_word;
		end else begin
			shreg <= shreg << 4;
		end
	end

	assign nibble = shreg[FRAME_W-1 -: 4];
	assign nibble_valid = (state == corr_frame_pkg::ser_send);
	assign frame_busy = (state == corr_frame_pkg::ser_send);

endmodule

`default_nettype wire

/* design/intensity_correlator_top.sv */
// intensity_correlator_top: sampler, correlator and serializer pipeline with plain ports.
`default_nettype none

module intensity_correlator_top #(
	parameter int NUM_INPUTS = corr_config_pkg::NUM_INPUTS_DEF,
	parameter int LAG_AUTO = corr_config_pkg::LAG_AUTO_DEF,
	parameter int RESOLUTION = corr_config_pkg::RESOLUTION_DEF
) (
	input wire pllclk,
	input wire reset,
	input wire [NUM_INPUTS-1:0] line_in,
	input wire [NUM_INPUTS-1:0] invert,
	input wire integrate,
	output corr_frame_pkg::nibble_t nibble,
	output logic nibble_valid,
	output logic frame_busy,
	output logic overrun
);

	// ******************************
	// stage links
	// ******************************

	pulse_if #(.NUM_INPUTS(NUM_INPUTS)) pulse_link ();

	result_if #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_AUTO(LAG_AUTO),
		.RESOLUTION(RESOLUTION)
	) result_link ();

	// ******************************
	// pipeline
	// ******************************

	line_sampler #(.NUM_INPUTS(NUM_INPUTS)) i_sampler (
		.pllclk(pllclk),
		.reset(reset),
		.line_in(line_in),
		.invert(invert),
		.integrate(integrate),
		.pulse_out(pulse_link.source)
	);

	lag_correlator #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_AUTO(LAG_AUTO),
		.RESOLUTION(RESOLUTION)
	) i_correlator (
		.pllclk(pllclk),
		.reset(reset),
		.pulse_in(pulse_link.sink),
		.result_out(result_link.source)
	);

	frame_serializer #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_AUTO(LAG_AUTO),
		.RESOLUTION(RESOLUTION)
	) i_serializer (
		.pllclk(pllclk),
		.reset(reset),
		.result_in(result_link.sink),
		.nibble(nibble),
		.nibble_valid(nibble_valid),
		.frame_busy(frame_busy),
		.overrun(overrun)
	);

endmodule

`default_nettype wire

/* verification/tb_tasks.svh */
// testbench tasks: value check, sample driver with the reference model, frame checks and tests.
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected) begin
		errors++;
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		$display("TEST FAIL");
		$fatal(1, "mismatch on %s", name);
	end
endtask

// ******************************
// reference model
// ******************************

// the first sample of a window restarts the total, later ones add and hold at full scale.
function automatic int tally(int total, logic hit, logic first);
	if (first) begin
		return int'(hit);
	end
	return (hit && total < (1 << R) - 1) ? total + 1 : total;
endfunction

task automatic drive_sample(input logic [N-1:0] lines, input logic [N-1:0] inv,
	input logic integ);
	logic [N-1:0] eff;
	logic [N-1:0] hits;
	logic first;
	int p;
	@(posedge pllclk);
	#DRIVE_DELAY;
	line_in = lines;
	invert = inv;
	integrate = integ;
	eff = lines ^ inv;
	hits = eff & ~prev_eff; // rising edges of this sample.
	first = integ & ~prev_integ;
	if (integ) begin
		p = 0;
		for (int i = 0; i < N; i++) begin
			m_counts[i] = tally(m_counts[i], hits[i], first);
			for (int d = 0; d < L; d++) begin
				m_autos[i][d] = tally(m_autos[i][d], hits[i] & edge_hist[d][i], first);
			end
			for (int j = i + 1; j < N; j++) begin
				m_crosses[p] = tally(m_crosses[p], hits[i] & hits[j], first);
				p++;
			end
		end
		if (first) begin
			m_samples = 32'd1;
		end else if (m_samples != '1) begin
			m_samples = m_samples + 1;
		end
	end
	for (int d = L - 1; d > 0; d--) begin
		edge_hist[d] = edge_hist[d - 1];
	end
	edge_hist[0] = hits; // history runs outside windows too.
	prev_eff = eff;
	prev_integ = integ;
endtask

// ******************************
// frame handling
// ******************************

function automatic void add_field(string name, int width, logic [31:0] value);
	exp_names.push_back(name);
	exp_widths.push_back(width);
	exp_values.push_back(value);
endfunction

task automatic snapshot_expected();
	int p;
	exp_names.delete();
	exp_widths.delete();
	exp_values.delete();
	add_field("header", corr_frame_pkg::HEADER_BITS,
		corr_frame_pkg::header_t'(((N - 1) << 12) | (L << 8) | R));
	add_field("sample_count", corr_frame_pkg::COUNT_BITS, m_samples);
	for (int i = 0; i < N; i++) begin
		add_field($sformatf("counts[%0d]", i), R, m_counts[i]);
	end
	for (int i = 0; i < N; i++) begin
		for (int d = 0; d < L; d++) begin
			add_field($sformatf("autos[%0d] lag %0d", i, d + 1), R, m_autos[i][d]);
		end
	end
	p = 0;
	for (int i = 0; i < N; i++) begin
		for (int j = i + 1; j < N; j++) begin
			add_field($sformatf("crosses[%0d,%0d]", i, j), R, m_crosses[p]);
			p++;
		end
	end
endtask

task automatic close_window();
	drive_sample(line_in, invert, 1'b0);
	snapshot_expected();
endtask

// holds the inputs until a frame has started and ended.
task automatic wait_frame();
	while (!frame_busy) begin
		drive_sample(line_in, invert, 1'b0);
	end
	while (frame_busy) begin
		drive_sample(line_in, invert, 1'b0);
	end
endtask

// reads count captured nibbles from index first on, most significant nibble first.
function automatic logic [31:0] captured_field(int first, int count);
	logic [31:0] value;
	value = '0;
	for (int n = first; n < first + count; n++) begin
		value = {value[27:0], captured[n]};
	end
	return value;
endfunction

task automatic compare_frame();
	logic bits [$];
	logic [31:0] actual;
	int pos;
	check_value("frame length", captured.size(), FRAME_NIBBLES);
	foreach (captured[n]) begin
		for (int b = 3; b >= 0; b--) begin
			bits.push_back(captured[n][b]);
		end
	end
	pos = 0;
	foreach (exp_names[f]) begin
		actual = '0;
		for (int b = 0; b < exp_widths[f]; b++) begin
			actual = {actual[30:0], bits[pos]};
			pos++;
		end
		check_value(exp_names[f], actual, exp_values[f]);
	end
	captured.delete();
endtask

task automatic close_and_check();
	close_window();
	wait_frame();
	compare_frame();
endtask

// ******************************
// directed tests
// ******************************

task automatic idle_after_reset();
	repeat (20) begin
		drive_sample('0, '0, 1'b0);
	end
	check_value("nibbles while idle", captured.size(), 0);
	check_value("overrun after reset", overrun, 0);
	for (int k = 0; k < WIN_SHORT; k++) begin
		drive_sample(N'(k), '0, 1'b1);
	end
	close_and_check();
endtask

// an edge two samples before the window pairs with the first edge inside it at lag 2.
task automatic pulse_train(input int line, input int spacing);
	logic [N-1:0] one;
	one = N'(1) << line;
	drive_sample('0, '0, 1'b0);
	drive_sample(one, '0, 1'b0);
	for (int k = 1; k <= WIN_SHORT; k++) begin
		drive_sample((k % (spacing + 1) == 0) ? one : '0, '0, 1'b1);
	end
	close_and_check();
endtask

task automatic coincident_lines();
	logic [N-1:0] pat;
	for (int k = 0; k < WIN_SHORT; k++) begin
		case (k % 4)
			0: pat = N'(5); // lines 0 and 2 together.
			2: pat = N'(2);
			default: pat = '0;
		endcase
		drive_sample(pat, '0, 1'b1);
	end
	close_and_check();
endtask

// line 1 inverted while its raw value is low, so each return to low is an edge.
task automatic inverted_line();
	drive_sample('0, N'(2), 1'b0);
	for (int k = 0; k < WIN_SHORT; k++) begin
		drive_sample((k % 5 == 2) ? N'(2) : '0, N'(2), 1'b1);
	end
	close_and_check();
endtask

task automatic long_random_window();
	logic [N-1:0] pat;
	for (int k = 0; k < WIN_LONG; k++) begin
		pat = N'($random(seed));
		pat[0] = k[0];
		drive_sample(pat, '0, 1'b1);
	end
	close_window();
	wait_frame();
	check_value("sample_count", captured_field(corr_frame_pkg::HEADER_BITS / 4,
		corr_frame_pkg::COUNT_BITS / 4), WIN_LONG);
	check_value("counts[0]", captured_field((corr_frame_pkg::HEADER_BITS
		+ corr_frame_pkg::COUNT_BITS) / 4, R / 4), (1 << R) - 1);
	compare_frame();
endtask

task automatic overlapped_windows();
	check_value("overrun before overlap", overrun, 0);
	for (int k = 0; k < WIN_SHORT; k++) begin
		drive_sample(N'(k), '0, 1'b1);
	end
	close_window();
	for (int k = 0; k < WIN_SHORT / 2; k++) begin
		drive_sample(N'(3 * k), '0, 1'b1);
	end
	drive_sample(line_in, invert, 1'b0); // second window ends while the first frame runs.
	wait_frame();
	compare_frame();
	check_value("overrun", overrun, 1);
	repeat (FRAME_NIBBLES) begin
		drive_sample(line_in, invert, 1'b0);
	end
	check_value("nibbles from the dropped frame", captured.size(), 0);
endtask

`endif

/* verification/tb_intensity_correlator.sv */
// testbench top: clock, reset, watchdog, DUT instance, nibble capture and the test sequence.
`default_nettype none

module tb_intensity_correlator;

	localparam int N = corr_config_pkg::NUM_INPUTS_DEF;
	localparam int L = corr_config_pkg::LAG_AUTO_DEF;
	localparam int R = corr_config_pkg::RESOLUTION_DEF;
	localparam int PAIRS = N * (N - 1) / 2;
	localparam int FRAME_NIBBLES = (corr_frame_pkg::HEADER_BITS + corr_frame_pkg::COUNT_BITS
		+ (N + N * L + PAIRS) * R + 3) / 4;
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int WIN_SHORT = 24;
	localparam int WIN_LONG = 140000; // line 0 toggles, so its edges overflow a 16-bit total.
	localparam int WINDOW_TOTAL = 7 * WIN_SHORT + WIN_SHORT / 2 + WIN_LONG;
	localparam int NUM_FRAMES = 8;
	localparam int WATCHDOG_CYCLES = 2 * (WINDOW_TOTAL + NUM_FRAMES * FRAME_NIBBLES);

	logic pllclk;
	logic reset;
	logic [N-1:0] line_in;
	logic [N-1:0] invert;
	logic integrate;
	corr_frame_pkg::nibble_t nibble;
	logic nibble_valid;
	logic frame_busy;
	logic overrun;

	integer seed;
	int errors;
	corr_frame_pkg::nibble_t captured [$];

	// ******************************
	// reference model state
	// ******************************

	logic [N-1:0] prev_eff; // line values after the invert mask, one sample back.
	logic prev_integ;
	logic [N-1:0] edge_hist [L]; // edge_hist[d] holds the edges of d+1 samples ago.
	int m_counts [N];
	int m_autos [N][L];
	int m_crosses [PAIRS];
	corr_config_pkg::sample_count_t m_samples;

	// expected fields of the next frame, in frame order.
	string exp_names [$];
	int exp_widths [$];
	logic [31:0] exp_values [$];

	intensity_correlator_top i_dut (
		.pllclk(pllclk),
		.reset(reset),
		.line_in(line_in),
		.invert(invert),
		.integrate(integrate),
		.nibble(nibble),
		.nibble_valid(nibble_valid),
		.frame_busy(frame_busy),
		.overrun(overrun)
	);

	initial begin
		pllclk = 1'b0;
		forever #(CLK_PERIOD / 2) pllclk = ~pllclk;
	end

	always @(posedge pllclk) begin
		if (nibble_valid) begin
			check_value("frame_busy", frame_busy, 1'b1); // every nibble lies inside a frame.
			captured.push_back(nibble);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	// ******************************
	// test sequence
	// ******************************

	initial begin
		seed = 70;
		errors = 0;
		reset = 1'b1;
		line_in = '0;
		invert = '0;
		integrate = 1'b0;
		prev_eff = '0;
		prev_integ = 1'b0;
		m_samples = '0;
		foreach (edge_hist[d]) begin
			edge_hist[d] = '0;
		end
		repeat (10) @(posedge pllclk);
		#DRIVE_DELAY;
		reset = 1'b0;
		idle_after_reset();
		pulse_train(0, 1);
		pulse_train(1, 2);
		pulse_train(2, 3);
		coincident_lines();
		inverted_line();
		long_random_window();
		overlapped_windows();
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	`include "tb_tasks.svh"

endmodule

`default_nettype wire

/* build.f */
+incdir+verification
design/corr_config_pkg.sv
design/corr_frame_pkg.sv
design/pulse_if.sv
design/line_sampler.sv
design/lag_correlator.sv
design/frame_serializer.sv
design/intensity_correlator_top.sv
verification/tb_intensity_correlator.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

TOP=tb_intensity_correlator
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module "$TOP" -Mdir obj_dir

./obj_dir/V"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
	echo "simulation ended without a result, see $LOG"
	exit 1
fi
echo "simulation passed"
